/* source/platformPkg.sv */
`default_nettype none

package platformPkg;

  // ----------------------------------------------------------
  // clocks
  // ----------------------------------------------------------
  localparam int unsigned systemClockFrequencyHz = 125000000;
  localparam int unsigned referenceClockFrequencyHz = 50000000;
  localparam int unsigned hertzPerMegahertz = 1000000;

  localparam int unsigned cyclesPerMicrosecondWidth = 7;
  localparam logic [cyclesPerMicrosecondWidth-1:0] cyclesPerMicrosecond =
    cyclesPerMicrosecondWidth'(systemClockFrequencyHz / hertzPerMegahertz);

  // one measurement window spans 1 us of reference clock
  localparam int unsigned referenceWindowCycles = referenceClockFrequencyHz / hertzPerMegahertz;
  localparam int unsigned referenceWindowCountWidth = $clog2(referenceWindowCycles);
  localparam int unsigned frequencyCountWidth = 16;

  // ----------------------------------------------------------
  // reset
  // ----------------------------------------------------------
  localparam int unsigned resetCountWidth = 5;

endpackage

`default_nettype wire

/* source/ciPkg.sv */
`default_nettype none

package ciPkg;

  typedef logic [7:0] ciId_t;
  typedef logic [31:0] ciWord_t;

  // same operand word, seen as a whole or as four byte lanes
  typedef union packed {
    ciWord_t word;
    logic [3:0][7:0] bytes;
  } ciDataWord_t;

  // ----------------------------------------------------------
  // instruction numbers
  // ----------------------------------------------------------
  localparam ciId_t byteSwapId = 8'd1;
  localparam ciId_t processorIdId = 8'd4;
  localparam ciId_t microDelayId = 8'd6;

  // fields of the processor id answer
  localparam logic [7:0] processorIdValue = 8'd1;
  localparam logic [7:0] numberOfProcessors = 8'd1;

endpackage

`default_nettype wire

/* source/ciBus.sv */
`timescale 1ns/10ps
`default_nettype none

interface ciBus import ciPkg::*; ();

  // request side
  logic start;
  ciId_t n;
  ciWord_t dataA;
  ciWord_t dataB;

  // answer side with result held at zero unless done is high
  logic done;
  ciWord_t result;

  modport requester (
    output start,
    output n,
    output dataA,
    output dataB,
    input done,
    input result
  );

  modport unit (
    input start,
    input n,
    input dataA,
    input dataB,
    output done,
    output result
  );

endinterface

`default_nettype wire

/* source/resetSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module resetSequencer import platformPkg::*; (
  input logic s_systemClock,
  input logic s_pllLocked,
  output logic coreReady
);

  logic [resetCountWidth-1:0] resetCount;

  // counts up after lock and parks once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[resetCountWidth-1]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign coreReady = resetCount[resetCountWidth-1];

endmodule

`default_nettype wire

/* source/byteSwapUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module byteSwapUnit import ciPkg::*; (
  input logic s_systemClock,
  input logic coreReady,
  ciBus.unit ci
);

  ciDataWord_t operand;
  ciDataWord_t swapped;
  logic unitEnable;
  logic selected;

  always_ff @(posedge s_systemClock) begin
    unitEnable <= coreReady;
  end

  assign operand = ci.dataA;

  // ----------------------------------------------------------
  // byte reordering
  // ----------------------------------------------------------
  always_comb begin
    if (ci.dataB[0]) begin
      // swap within each 16-bit half
      swapped.bytes = {operand.bytes[2], operand.bytes[3],
                       operand.bytes[0], operand.bytes[1]};
    end else begin
      // full endian reversal
      swapped.bytes = {operand.bytes[0], operand.bytes[1],
                       operand.bytes[2], operand.bytes[3]};
    end
  end

  assign selected = ci.start && (ci.n == byteSwapId) && unitEnable;

  assign ci.done = selected;
  assign ci.result = selected ? swapped.word : '0;

endmodule

`default_nettype wire

/* source/processorIdUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module processorIdUnit import platformPkg::*, ciPkg::*; (
  input logic s_systemClock,
  input logic coreReady,
  input logic referenceClock,
  ciBus.unit ci
);

  logic referenceToggle;
  logic [2:0] toggleSync;
  logic referenceEdge;
  logic windowEnd;
  logic [referenceWindowCountWidth-1:0] edgeCount;
  logic [frequencyCountWidth-1:0] cycleCount;
  logic [frequencyCountWidth-1:0] frequencyMhz;
  logic firstWindowDone;
  logic unitEnable;
  logic selected;
  ciDataWord_t idWord;

  // ----------------------------------------------------------
  // reference clock domain
  // ----------------------------------------------------------
  always_ff @(posedge referenceClock or negedge coreReady) begin
    if (!coreReady) begin
      referenceToggle <= 1'b0;
    end else begin
      referenceToggle <= ~referenceToggle;
    end
  end

  // ----------------------------------------------------------
  // system clock domain
  // ----------------------------------------------------------
  // bits 1..0 synchronize, bit 2 keeps the previous value for edge detect
  assign referenceEdge = toggleSync[2] ^ toggleSync[1];
  assign windowEnd = referenceEdge &&
                     (edgeCount == referenceWindowCountWidth'(referenceWindowCycles - 1));

  always_ff @(posedge s_systemClock) begin
    if (!coreReady) begin
      unitEnable <= 1'b0;
      toggleSync <= '0;
      edgeCount <= '0;
      cycleCount <= '0;
      frequencyMhz <= '0;
      firstWindowDone <= 1'b0;
    end else begin
      unitEnable <= 1'b1;
      toggleSync <= {toggleSync[1:0], referenceToggle};
      if (windowEnd) begin
        edgeCount <= '0;
        cycleCount <= '0;
        firstWindowDone <= 1'b1;
        // first window starts at reset release, not on an edge, so it is dropped
        if (firstWindowDone) begin
          frequencyMhz <= cycleCount + 1'b1;
        end
      end else begin
        cycleCount <= cycleCount + 1'b1;
        if (referenceEdge) begin
          edgeCount <= edgeCount + 1'b1;
        end
      end
    end
  end

  assign idWord.word = {processorIdValue, numberOfProcessors, frequencyMhz};

  assign selected = ci.start && (ci.n == processorIdId) && unitEnable;

  assign ci.done = selected;
  assign ci.result = selected ? idWord.word : '0;

endmodule

`default_nettype wire

/* source/microDelayUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module microDelayUnit import platformPkg::*, ciPkg::*; (
  input logic s_systemClock,
  input logic coreReady,
  ciBus.unit ci
);

  ciDataWord_t delayValue;
  ciWord_t microseconds;
  logic [cyclesPerMicrosecondWidth-1:0] prescaler;
  logic busy;
  logic startDelay;
  logic finished;

  assign delayValue = ci.dataA;

  // a start while busy is ignored
  assign startDelay = ci.start && (ci.n == microDelayId) && !busy;
  assign finished = busy && (microseconds == '0);

  // ----------------------------------------------------------
  // control
  // ----------------------------------------------------------
  always_ff @(posedge s_systemClock) begin
    if (!coreReady) begin
      busy <= 1'b0;
    end else if (startDelay) begin
      busy <= 1'b1;
    end else if (finished) begin
      busy <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // microsecond countdown
  // ----------------------------------------------------------
  always_ff @(posedge s_systemClock) begin
    if (startDelay) begin
      microseconds <= delayValue.word;
      prescaler <= cyclesPerMicrosecond - 1'b1;
    end else if (busy && !finished) begin
      if (prescaler == '0) begin
        microseconds <= microseconds - 1'b1;
        prescaler <= cyclesPerMicrosecond - 1'b1;
      end else begin
        prescaler <= prescaler - 1'b1;
      end
    end
  end

  // the delay returns no data
  assign ci.done = finished;
  assign ci.result = '0;

endmodule

`default_nettype wire

/* source/ciSubsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module ciSubsystem import ciPkg::*; (
  input logic s_systemClock,
  input logic s_pllLocked,
  input logic referenceClock,
  input logic ciStart,
  input ciId_t ciN,
  input ciWord_t ciDataA,
  input ciWord_t ciDataB,
  output logic ciDone,
  output ciWord_t ciResult,
  output logic coreReady
);

  ciBus swapBus ();
  ciBus idBus ();
  ciBus delayBus ();

  resetSequencer resetSeq (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .coreReady(coreReady)
  );

  // ----------------------------------------------------------
  // every unit sees the same request
  // ----------------------------------------------------------
  assign swapBus.start = ciStart;
  assign swapBus.n = ciN;
  assign swapBus.dataA = ciDataA;
  assign swapBus.dataB = ciDataB;

  assign idBus.start = ciStart;
  assign idBus.n = ciN;
  assign idBus.dataA = ciDataA;
  assign idBus.dataB = ciDataB;

  assign delayBus.start = ciStart;
  assign delayBus.n = ciN;
  assign delayBus.dataA = ciDataA;
  assign delayBus.dataB = ciDataB;

  byteSwapUnit swapUnit (
    .s_systemClock(s_systemClock),
    .coreReady(coreReady),
    .ci(swapBus)
  );

  processorIdUnit idUnit (
    .s_systemClock(s_systemClock),
    .coreReady(coreReady),
    .referenceClock(referenceClock),
    .ci(idBus)
  );

  microDelayUnit delayUnit (
    .s_systemClock(s_systemClock),
    .coreReady(coreReady),
    .ci(delayBus)
  );

  // idle units answer with zeros, so a plain OR merges them
  assign ciDone = swapBus.done | idBus.done | delayBus.done;
  assign ciResult = swapBus.result | idBus.result | delayBus.result;

endmodule

`default_nettype wire

/* tests/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGen (
  output logic s_systemClock,
  output logic referenceClock,
  output logic s_pllLocked
);

  localparam int unsigned lockDelayCycles = 5;

  initial begin
    s_systemClock = 1'b0;
    referenceClock = 1'b0;
    s_pllLocked = 1'b0;
    // lock comes after a few system clocks
    repeat (lockDelayCycles) @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
  end

  // 8 ns system clock, 20 ns reference clock
  always #4 s_systemClock = ~s_systemClock;
  always #10 referenceClock = ~referenceClock;

endmodule

`default_nettype wire

/* tests/ciSubsystemTb.sv */
`timescale 1ns/10ps
`default_nettype none

module ciSubsystemTb import ciPkg::*; ();

  localparam int unsigned tableLength = 10;
  localparam int unsigned resetStretchCycles = 16;
  localparam int unsigned clocksPerMicrosecond = 125;
  localparam int unsigned settleCycles = 3 * clocksPerMicrosecond;
  localparam int unsigned watchdogMarginCycles = 5000;

  typedef struct packed {
    ciId_t n;
    ciWord_t dataA;
    ciWord_t dataB;
    ciWord_t expResult;
    ciWord_t tolerance;
    int unsigned latency;
  } stimulusEntry_t;

  logic s_systemClock;
  logic s_pllLocked;
  logic referenceClock;
  logic ciStart;
  ciId_t ciN;
  ciWord_t ciDataA;
  ciWord_t ciDataB;
  logic ciDone;
  ciWord_t ciResult;
  logic coreReady;

  stimulusEntry_t stimulusTable [tableLength];
  integer seed = 53;
  int unsigned watchdogCycles = 0;

  clockGen clocks (
    .s_systemClock(s_systemClock),
    .referenceClock(referenceClock),
    .s_pllLocked(s_pllLocked)
  );

  ciSubsystem UUT (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .referenceClock(referenceClock),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .ciDone(ciDone),
    .ciResult(ciResult),
    .coreReady(coreReady)
  );

  // ----------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------
  task automatic stopRun();
    $display("Test FAILED");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic checkResult(input ciWord_t actual, input ciWord_t expected,
                             input ciWord_t tolerance, input string what);
    ciWord_t difference;
    difference = (actual > expected) ? actual - expected : expected - actual;
    if ($isunknown(actual) || difference > tolerance) begin
      $display("Fail at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, actual, expected);
      stopRun();
    end
  endtask

  task automatic checkLatency(input int unsigned actual, input int unsigned expected,
                              input string what);
    if (actual != expected) begin
      $display("Fail at %0t ns: %s took %0d cycles, expected %0d", $time, what, actual, expected);
      stopRun();
    end
  endtask

  task automatic checkFlag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
      stopRun();
    end
  endtask

  // ----------------------------------------------------------
  // expected values
  // ----------------------------------------------------------
  function automatic ciWord_t reverseBytes(input ciWord_t value);
    return {value[7:0], value[15:8], value[23:16], value[31:24]};
  endfunction

  function automatic ciWord_t swapWithinHalves(input ciWord_t value);
    return {value[23:16], value[31:24], value[7:0], value[15:8]};
  endfunction

  function automatic stimulusEntry_t makeEntry(input ciId_t n, input ciWord_t dataA,
      input ciWord_t dataB, input ciWord_t expResult, input ciWord_t tolerance,
      input int unsigned latency);
    stimulusEntry_t entry;
    entry.n = n;
    entry.dataA = dataA;
    entry.dataB = dataB;
    entry.expResult = expResult;
    entry.tolerance = tolerance;
    entry.latency = latency;
    return entry;
  endfunction

  task automatic buildTable();
    ciWord_t operand;
    ciWord_t selector;
    for (int i = 0; i < 3; i++) begin
      operand = $random(seed);
      selector = $random(seed);
      stimulusTable[i] = makeEntry(byteSwapId, operand, selector & ~32'd1,
                                   reverseBytes(operand), '0, 0);
      operand = $random(seed);
      selector = $random(seed);
      stimulusTable[i + 3] = makeEntry(byteSwapId, operand, selector | 32'd1,
                                       swapWithinHalves(operand), '0, 0);
    end
    // measured MHz may be off by one count
    stimulusTable[6] = makeEntry(processorIdId, '0, '0, {8'd1, 8'd1, 16'd125}, 32'd1, 0);
    stimulusTable[7] = makeEntry(microDelayId, 32'd0, '0, '0, '0, 1);
    stimulusTable[8] = makeEntry(microDelayId, 32'd1, '0, '0, '0, clocksPerMicrosecond + 1);
    stimulusTable[9] = makeEntry(microDelayId, 32'd3, '0, '0, '0,
                                 3 * clocksPerMicrosecond + 1);
  endtask

  // ----------------------------------------------------------
  // sequences
  // ----------------------------------------------------------
  task automatic checkReset();
    int unsigned cycles;
    while (s_pllLocked !== 1'b1) begin
      @(negedge s_systemClock);
      if (s_pllLocked !== 1'b1) begin
        checkFlag(coreReady, 1'b0, "coreReady while unlocked");
        checkFlag(ciDone, 1'b0, "ciDone while unlocked");
        checkResult(ciResult, '0, '0, "ciResult while unlocked");
      end
    end
    // lock rose on the last rising edge
    cycles = 0;
    while (coreReady !== 1'b1 && cycles < 4 * resetStretchCycles) begin
      @(posedge s_systemClock);
      cycles++;
      @(negedge s_systemClock);
    end
    checkLatency(cycles, resetStretchCycles, "coreReady after lock");
  endtask

  task automatic applyEntry(input stimulusEntry_t entry, input int index);
    int unsigned cycles;
    logic done;
    ciWord_t result;
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN <= entry.n;
    ciDataA <= entry.dataA;
    ciDataB <= entry.dataB;
    @(negedge s_systemClock);
    cycles = 0;
    done = ciDone;
    result = ciResult;
    @(posedge s_systemClock);
    ciStart <= 1'b0;
    while (done !== 1'b1 && cycles < entry.latency + 1) begin
      checkFlag(done, 1'b0, $sformatf("entry %0d early done", index));
      checkResult(result, '0, '0, $sformatf("entry %0d idle result", index));
      @(negedge s_systemClock);
      cycles++;
      done = ciDone;
      result = ciResult;
    end
    checkFlag(done, 1'b1, $sformatf("entry %0d done", index));
    checkLatency(cycles, entry.latency, $sformatf("entry %0d", index));
    checkResult(result, entry.expResult, entry.tolerance, $sformatf("entry %0d result", index));
    @(negedge s_systemClock);
    checkFlag(ciDone, 1'b0, $sformatf("entry %0d done after pulse", index));
  endtask

  initial begin : mainSequence
    int unsigned totalLatency;
    ciStart = 1'b0;
    ciN = '0;
    ciDataA = '0;
    ciDataB = '0;
    buildTable();
    totalLatency = 0;
    for (int i = 0; i < tableLength; i++) begin
      totalLatency += stimulusTable[i].latency;
    end
    watchdogCycles = totalLatency + watchdogMarginCycles;
    checkReset();
    // give the frequency counter time for a full window
    repeat (settleCycles) @(posedge s_systemClock);
    for (int i = 0; i < tableLength; i++) begin
      applyEntry(stimulusTable[i], i);
    end
    $display("Test OK");
    $finish;
  end

  initial begin : watchdog
    wait (watchdogCycles != 0);
    repeat (watchdogCycles) @(posedge s_systemClock);
    $display("Error: the run timed out after %0d cycles", watchdogCycles);
    stopRun();
  end

endmodule

`default_nettype wire

/* verilog.f */
source/platformPkg.sv
source/ciPkg.sv
source/ciBus.sv
source/resetSequencer.sv
source/byteSwapUnit.sv
source/processorIdUnit.sv
source/microDelayUnit.sv
source/ciSubsystem.sv
tests/clockGen.sv
tests/ciSubsystemTb.sv

/* Bender.yml */
package:
  name: ciSubsystem

sources:
  # design, packages first
  - files:
      - source/platformPkg.sv
      - source/ciPkg.sv
      - source/ciBus.sv
      - source/resetSequencer.sv
      - source/byteSwapUnit.sv
      - source/processorIdUnit.sv
      - source/microDelayUnit.sv
      - source/ciSubsystem.sv
  # testbench
  - target: test
    files:
      - tests/clockGen.sv
      - tests/ciSubsystemTb.sv
